// ==== sources.f ====
source/isa_pkg.sv
source/mem_map_pkg.sv
source/program_counter.sv
source/branch_ctrl.sv
source/return_stack.sv
source/instr_fetch.sv
bench/prog_rom.sv
bench/tb_instr_fetch.sv

// ==== Makefile ====
# Verilator build and run for the instruction fetch unit
# Any variable can be overridden on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_instr_fetch
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit code
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_instr_fetch.sv ====
// Testbench for the instruction fetch unit
// Directed tests checked against a reference fetch model
`default_nettype none

module tb_instr_fetch;

	timeunit 1ns;
	timeprecision 1ps;

	import isa_pkg::*;
	import mem_map_pkg::*;

	localparam int SEED      = 49658;
	localparam int RUN_LIMIT = 64;
	localparam int WATCHDOG  = 2000;

	logic                 clk;
	logic                 rst;
	logic                 itr;
	logic                 acc_lsb;
	instr_t               instr;
	iaddr_t               instr_addr;
	logic [OPCODE_W-1:0]  opcode;
	logic [OPERAND_W-1:0] operand;

	// Reference model, running pc and return stack
	iaddr_t model_pc;
	instr_t model_instr;
	iaddr_t model_stack [$];
	// Addresses the DUT presented, one per cycle
	iaddr_t trace [$];
	int     errors;

	instr_fetch u_dut (
		.clk        (clk),
		.rst        (rst),
		.itr        (itr),
		.acc_lsb    (acc_lsb),
		.instr      (instr),
		.instr_addr (instr_addr),
		.opcode     (opcode),
		.operand    (operand)
	);

	prog_rom u_rom (
		.clk   (clk),
		.rst   (rst),
		.addr  (instr_addr),
		.instr (instr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// Model and helpers
	// --------------------------------------------------

	// Fetch address rule, first match wins
	function automatic iaddr_t expected_fetch(input instr_t word, input logic itr_v,
	                                          input logic acc_v);
		if (itr_v) return ITR_VECTOR;
		if (word.opcode == OP_RET) return model_stack[$];
		if (word.opcode == OP_JMP || word.opcode == OP_CAL) return word.operand[IADDR_W-1:0];
		if (word.opcode == OP_JIZ && !acc_v) return word.operand[IADDR_W-1:0];
		return model_pc;
	endfunction

	// Non-branch opcodes, operand carries the full address
	task automatic load_filler();
		instr_t word;
		for (int a = 0; a < 2**IADDR_W; a++) begin
			word.opcode  = OPCODE_W'($urandom % 12);
			word.operand = OPERAND_W'(a);
			u_rom.mem[a] = word;
		end
	endtask

	task automatic place_branch(input iaddr_t addr, input logic [OPCODE_W-1:0] op,
	                            input iaddr_t target);
		u_rom.mem[addr] = '{opcode: op, operand: target};
	endtask

	// 10 cycles of reset, released on a falling edge
	task automatic apply_reset();
		@(negedge clk);
		rst     = 1'b1;
		itr     = 1'b0;
		acc_lsb = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst         = 1'b0;
		model_pc    = '0;
		model_instr = '0;
		model_stack.delete();
		trace.delete();
	endtask

	// Starts on a falling edge, ends on the next one
	task automatic step_cycle(input logic itr_v, input logic acc_v);
		iaddr_t exp_addr;
		itr     = itr_v;
		acc_lsb = acc_v;
		#2;
		exp_addr = expected_fetch(model_instr, itr_v, acc_v);
		if (instr_addr !== exp_addr) begin
			errors++;
			$display("ERROR %0t: instr_addr %0d, expected %0d", $time, instr_addr, exp_addr);
		end
		if (opcode !== model_instr.opcode || operand !== model_instr.operand) begin
			errors++;
			$display("ERROR %0t: opcode/operand %0d/%0d, expected %0d/%0d", $time,
			         opcode, operand, model_instr.opcode, model_instr.operand);
		end
		// Interrupt blocks stack traffic
		if (!itr_v && model_instr.opcode == OP_CAL) model_stack.push_back(model_pc);
		if (!itr_v && model_instr.opcode == OP_RET) void'(model_stack.pop_back());
		model_pc    = exp_addr + iaddr_t'(1);
		model_instr = u_rom.mem[exp_addr];
		trace.push_back(instr_addr);
		@(negedge clk);
	endtask

	task automatic run_until(input iaddr_t target);
		int n;
		n = 0;
		while (trace.size() == 0 || trace[$] !== target) begin
			if (n == RUN_LIMIT) begin
				errors++;
				$display("fetch never reached address %0d within %0d cycles", target, RUN_LIMIT);
				return;
			end
			step_cycle(1'b0, 1'($urandom));
			n++;
		end
	endtask

	// Compare the first n fetches with a fixed sequence
	task automatic check_trace(input iaddr_t exp [9], input int n, input string name);
		if (trace.size() != n) begin
			errors++;
			$display("%s recorded %0d fetches instead of %0d", name, trace.size(), n);
			return;
		end
		for (int i = 0; i < n; i++) begin
			if (trace[i] !== exp[i]) begin
				errors++;
				$display("ERROR %0t: %s fetch %0d at %0d, expected %0d", $time, name, i,
				         trace[i], exp[i]);
			end
		end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------

	task automatic sequential_fetch();
		load_filler();
		apply_reset();
		repeat (20) step_cycle(1'b0, 1'($urandom));
		for (int i = 0; i < 20; i++) begin
			if (trace[i] !== iaddr_t'(i)) begin
				errors++;
				$display("ERROR %0t: sequential fetch %0d at %0d", $time, i, trace[i]);
			end
		end
	endtask

	// No bubble, 40 follows 3 directly
	task automatic jump_redirect();
		load_filler();
		place_branch(9'd3, OP_JMP, 9'd40);
		apply_reset();
		run_until(9'd42);
		check_trace('{0, 1, 2, 3, 40, 41, 42, 0, 0}, 7, "jump");
	endtask

	// Falls through at 2, taken at 6
	task automatic conditional_jump();
		load_filler();
		place_branch(9'd2, OP_JIZ, 9'd60);
		place_branch(9'd6, OP_JIZ, 9'd80);
		apply_reset();
		repeat (4) step_cycle(1'b0, 1'b1);
		repeat (5) step_cycle(1'b0, 1'b0);
		check_trace('{0, 1, 2, 3, 4, 5, 6, 80, 81}, 9, "jiz");
	endtask

	task automatic nested_call_return();
		load_filler();
		place_branch(9'd2, OP_CAL, 9'd50);
		place_branch(9'd50, OP_CAL, 9'd100);
		place_branch(9'd100, OP_RET, 9'd0);
		place_branch(9'd51, OP_RET, 9'd0);
		apply_reset();
		run_until(9'd5);
		check_trace('{0, 1, 2, 50, 100, 51, 3, 4, 5}, 9, "call");
	endtask

	// Interrupt lands on the RET at 31 inside a subroutine
	// so the RET at 6 must still find 3
	task automatic interrupt_vector();
		load_filler();
		place_branch(9'd2, OP_CAL, 9'd30);
		place_branch(9'd31, OP_RET, 9'd0);
		place_branch(9'd6, OP_RET, 9'd0);
		apply_reset();
		repeat (5) step_cycle(1'b0, 1'($urandom));
		step_cycle(1'b1, 1'($urandom));
		run_until(9'd3);
		check_trace('{0, 1, 2, 30, 31, 4, 5, 6, 3}, 9, "interrupt");
	endtask

	initial begin
		errors  = 0;
		rst     = 1'b1;
		itr     = 1'b0;
		acc_lsb = 1'b0;
		void'($urandom(SEED));
		sequential_fetch();
		jump_redirect();
		conditional_jump();
		nested_call_return();
		interrupt_vector();
		$display("checks complete, errors: %0d", errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Hard limit on run length
	initial begin
		for (int c = 0; c < WATCHDOG; c++) @(posedge clk);
		$display("simulation ran past %0d cycles without finishing", WATCHDOG);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/prog_rom.sv ====
// Instruction memory model
// Synchronous read, output register clears on reset
`default_nettype none

module prog_rom (
	input  logic                clk,
	input  logic                rst,
	input  mem_map_pkg::iaddr_t addr,
	output isa_pkg::instr_t     instr
);

	timeunit 1ns;
	timeprecision 1ps;

	import isa_pkg::*;
	import mem_map_pkg::*;

	// ------------------------------------------------
	// Storage, written by the testbench
	// ------------------------------------------------

	// One word per instruction address
	instr_t mem [2**IADDR_W];

	// Word at addr shows up one cycle later
	// cleared output is opcode 0, not a branch
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			instr <= '0;
		end else begin
			instr <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== source/instr_fetch.sv ====
// Instruction fetch unit
// Program counter, branch control and return stack around
// a synchronous instruction memory
`default_nettype none

module instr_fetch (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          itr,
	input  logic                          acc_lsb,
	input  isa_pkg::instr_t               instr,
	output mem_map_pkg::iaddr_t           instr_addr,
	output logic [isa_pkg::OPCODE_W-1:0]  opcode,
	output logic [isa_pkg::OPERAND_W-1:0] operand
);

	import isa_pkg::*;
	import mem_map_pkg::*;

	// Counter and stack handshake with branch control
	logic      pc_load;
	iaddr_t    pc_target;
	iaddr_t    pc_addr;
	iaddr_t    top;
	stack_op_t stack_op;

	// ------------------------------------------------
	// Fetch datapath
	// ------------------------------------------------

	program_counter u_pc (
		.clk       (clk),
		.rst       (rst),
		.pc_load   (pc_load),
		.pc_target (pc_target),
		.pc_addr   (pc_addr)
	);

	// Memory address comes straight from the decode
	branch_ctrl u_branch (
		.instr      (instr),
		.acc_lsb    (acc_lsb),
		.itr        (itr),
		.pc_addr    (pc_addr),
		.top        (top),
		.fetch_addr (instr_addr),
		.pc_load    (pc_load),
		.pc_target  (pc_target),
		.stack_op   (stack_op)
	);

	// CAL saves the address after the call
	return_stack u_rstack (
		.clk       (clk),
		.rst       (rst),
		.stack_op  (stack_op),
		.push_addr (pc_addr),
		.top       (top)
	);

	// Fields for the downstream decoder
	assign opcode  = instr.opcode;
	assign operand = instr.operand;

endmodule

`default_nettype wire

// ==== source/return_stack.sv ====
// Subroutine return-address stack
// LIFO of fetch addresses, top shows the latest push
`default_nettype none

module return_stack #(
	parameter int DEPTH = mem_map_pkg::RSTACK_DEPTH
) (
	input  logic                clk,
	input  logic                rst,
	input  isa_pkg::stack_op_t  stack_op,
	input  mem_map_pkg::iaddr_t push_addr,
	output mem_map_pkg::iaddr_t top
);

	import isa_pkg::*;
	import mem_map_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);

	// ------------------------------------------------
	// Storage and occupancy
	// ------------------------------------------------

	iaddr_t entries [DEPTH];

	// Number of valid entries, also the next free slot
	logic [RSTACK_PTR_W-1:0] ptr;
	logic [IDX_W-1:0]        wr_idx;
	logic [IDX_W-1:0]        rd_idx;

	assign wr_idx = ptr[IDX_W-1:0];
	// Entry just below the pointer
	assign rd_idx = IDX_W'(ptr - RSTACK_PTR_W'(1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (stack_op.push) begin
			ptr <= ptr + RSTACK_PTR_W'(1);
		end else if (stack_op.pop) begin
			ptr <= ptr - RSTACK_PTR_W'(1);
		end
	end

	// Entries hold no control state
	always_ff @(posedge clk) begin
		if (stack_op.push) begin
			entries[wr_idx] <= push_addr;
		end
	end

	// Combinational from the pointer
	assign top = entries[rd_idx];

	// ------------------------------------------------
	// Occupancy checks
	// ------------------------------------------------

	// Call nesting must stay within DEPTH
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		stack_op.push |-> (ptr != RSTACK_PTR_W'(DEPTH)))
		else $error("return stack push while full");

	// Every RET needs an earlier CAL
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		stack_op.pop |-> (ptr != '0))
		else $error("return stack pop while empty");

endmodule

`default_nettype wire

// ==== source/branch_ctrl.sv ====
// Branch control
// Decodes JMP, JIZ, CAL and RET, picks the fetch address
// and requests return-stack pushes and pops
`default_nettype none

module branch_ctrl (
	input  isa_pkg::instr_t        instr,
	input  logic                   acc_lsb,
	input  logic                   itr,
	input  mem_map_pkg::iaddr_t    pc_addr,
	input  mem_map_pkg::iaddr_t    top,
	output mem_map_pkg::iaddr_t    fetch_addr,
	output logic                   pc_load,
	output mem_map_pkg::iaddr_t    pc_target,
	output isa_pkg::stack_op_t     stack_op
);

	import isa_pkg::*;
	import mem_map_pkg::*;

	// ------------------------------------------------
	// Opcode decode
	// ------------------------------------------------

	logic   is_jmp;
	logic   is_jiz;
	logic   is_cal;
	logic   is_ret;
	logic   jump_taken;
	iaddr_t jump_addr;

	assign is_jmp = (instr.opcode == OP_JMP);
	assign is_jiz = (instr.opcode == OP_JIZ);
	assign is_cal = (instr.opcode == OP_CAL);
	assign is_ret = (instr.opcode == OP_RET);

	// JIZ only branches with accumulator bit clear
	assign jump_taken = is_jmp | is_cal | (is_jiz & ~acc_lsb);

	// Target is the low part of the operand
	assign jump_addr = instr.operand[IADDR_W-1:0];

	// ------------------------------------------------
	// Fetch address priority
	// ------------------------------------------------

	// Interrupt first, then return, then jumps
	always_comb begin
		if (itr) begin
			fetch_addr = ITR_VECTOR;
		end else if (is_ret) begin
			fetch_addr = top;
		end else if (jump_taken) begin
			fetch_addr = jump_addr;
		end else begin
			fetch_addr = pc_addr;
		end
	end

	// Counter reloads whenever the flow leaves pc_addr
	assign pc_load   = itr | is_ret | jump_taken;
	assign pc_target = fetch_addr;

	// ------------------------------------------------
	// Return-stack requests
	// ------------------------------------------------

	// Interrupt overrides the call or return in flight
	always_comb begin
		stack_op.push = is_cal & ~itr;
		stack_op.pop  = is_ret & ~itr;
	end

endmodule

`default_nettype wire

// ==== source/program_counter.sv ====
// Program counter
// Holds the address after the last fetched one, reloads on redirect
`default_nettype none

module program_counter (
	input  logic                clk,
	input  logic                rst,
	input  logic                pc_load,
	input  mem_map_pkg::iaddr_t pc_target,
	output mem_map_pkg::iaddr_t pc_addr
);

	import mem_map_pkg::*;

	// ------------------------------------------------
	// Next-address selection
	// ------------------------------------------------

	// Address fetched this cycle
	iaddr_t fetched;

	// Redirected fetch or plain sequential fetch
	assign fetched = pc_load ? pc_target : pc_addr;

	// ------------------------------------------------
	// Counter register
	// ------------------------------------------------

	// Always points one past the word just fetched
	// wraps at the top of the address space
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc_addr <= '0;
		end else begin
			pc_addr <= fetched + iaddr_t'(1);
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_map_pkg.sv ====
// Instruction memory map for the fetch unit
// Address width, interrupt vector and return-stack geometry
`default_nettype none

package mem_map_pkg;

	// ------------------------------------------------
	// Instruction address space
	// ------------------------------------------------

	localparam int IADDR_W = 9;

	typedef logic [IADDR_W-1:0] iaddr_t;

	// Fixed entry point of the interrupt handler
	localparam iaddr_t ITR_VECTOR = 9'd4;

	// ------------------------------------------------
	// Subroutine return stack
	// ------------------------------------------------

	localparam int RSTACK_DEPTH = 8;
	// Counts 0 to RSTACK_DEPTH, so one bit above the index
	localparam int RSTACK_PTR_W = $clog2(RSTACK_DEPTH + 1);

endpackage

`default_nettype wire

// ==== source/isa_pkg.sv ====
// Instruction set definitions for the fetch unit
// Field widths, branch opcodes and instruction-level structs
`default_nettype none

package isa_pkg;

	// ------------------------------------------------
	// Instruction word layout
	// ------------------------------------------------

	// Opcode sits above the operand
	localparam int OPCODE_W  = 7;
	localparam int OPERAND_W = 9;
	localparam int INSTR_W   = OPCODE_W + OPERAND_W;

	// ------------------------------------------------
	// Flow-control opcodes
	// ------------------------------------------------

	localparam logic [OPCODE_W-1:0] OP_JMP = 7'd12;
	localparam logic [OPCODE_W-1:0] OP_JIZ = 7'd13;
	localparam logic [OPCODE_W-1:0] OP_CAL = 7'd14;
	localparam logic [OPCODE_W-1:0] OP_RET = 7'd15;

	// One word as returned by instruction memory
	typedef struct packed {
		logic [OPCODE_W-1:0]  opcode;
		logic [OPERAND_W-1:0] operand;
	} instr_t;

	// Return-stack request, at most one bit set
	typedef struct packed {
		logic push;
		logic pop;
	} stack_op_t;

endpackage

`default_nettype wire
